/* sub8_fpu.f */
+incdir+include
rtl/sub8_fpu_pkg.sv
rtl/sub8_issue.sv
rtl/sub8_lane.sv
rtl/sub8_collect.sv
rtl/sub8_fpu_top.sv
testbench/tb_sub8_fpu.sv

/* Makefile */
# Verilator build for the sub-8 FPU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_sub8_fpu \
		-f sub8_fpu.f -Mdir obj_dir -o tb_sub8_fpu

run: compile
	./obj_dir/tb_sub8_fpu

clean:
	rm -rf obj_dir

/* include/tb_vectors.svh */
// Directed test vectors
// Columns: name, op, sub-op, format code, replicate, operand A, operand B,
//          tag, expected result, expected invalid (lane 0 in the low byte)

task automatic build_table();
    // Sign injection, one row per format
    add_row("sgnj_e5m2", SGNJ, 3'd0, 4'h1, 1'b0, 32'h3CBC7C01, 32'h80008000, 4'h0, 32'hBC3CFC01, 1'b0);
    add_row("sgnjn_e5m2", SGNJ, 3'd1, 4'h1, 1'b0, 32'h3CBC7C01, 32'h80008000, 4'h1, 32'h3CBC7C81, 1'b0);
    add_row("sgnjx_e5m2", SGNJ, 3'd2, 4'h1, 1'b0, 32'h3CBC7C01, 32'h80008000, 4'h2, 32'hBCBCFC01, 1'b0);
    add_row("sgnj_e4m3", SGNJ, 3'd0, 4'h2, 1'b0, 32'h7F40C138, 32'h00800080, 4'h3, 32'h7FC041B8, 1'b0);
    add_row("sgnj_e3m2", SGNJ, 3'd0, 4'h3, 1'b0, 32'h0C213F05, 32'h20002000, 4'h4, 32'hECC1FFC5, 1'b0);
    add_row("sgnjn_e2m3", SGNJ, 3'd1, 4'h4, 1'b0, 32'hFF123300, 32'h20002000, 4'h5, 32'hDFF2D3E0, 1'b0);
    add_row("sgnjx_e2m1", SGNJ, 3'd2, 4'h5, 1'b0, 32'h0F08A307, 32'h08080008, 4'h6, 32'hF7F0F3FF, 1'b0);
    // Moves, boxed and raw
    add_row("x2f_e3m2", X2F, 3'd0, 4'h3, 1'b0, 32'h123FC005, 32'h00000000, 4'h7, 32'hD2FFC0C5, 1'b0);
    add_row("x2f_e2m3", X2F, 3'd0, 4'h4, 1'b0, 32'h00112233, 32'h00000000, 4'h8, 32'hC0D1E2F3, 1'b0);
    add_row("x2f_e2m1", X2F, 3'd0, 4'h5, 1'b0, 32'h01020304, 32'h00000000, 4'h9, 32'hF1F2F3F4, 1'b0);
    add_row("f2x_e2m1", F2X, 3'd0, 4'h5, 1'b0, 32'h123FC005, 32'h00000000, 4'hA, 32'h123FC005, 1'b0);
    add_row("f2x_e5m2", F2X, 3'd0, 4'h1, 1'b0, 32'hDEADBEEF, 32'h00000000, 4'hB, 32'hDEADBEEF, 1'b0);
    // Min and max, signed zeros and NaNs
    add_row("min_zero_snan", MINMAX, 3'd0, 4'h1, 1'b0, 32'h7E7D0080, 32'h3C3C8000, 4'hC, 32'h3C3C8080, 1'b1);
    add_row("max_zero_snan", MINMAX, 3'd1, 4'h1, 1'b0, 32'h7E7D0080, 32'h3C3C8000, 4'hD, 32'h3C3C0000, 1'b1);
    add_row("min_nan_e5m2", MINMAX, 3'd0, 4'h1, 1'b0, 32'h7E7FFF3C, 32'h7FFEC0BC, 4'hE, 32'h7E7EC0BC, 1'b0);
    add_row("min_nan_e4m3", MINMAX, 3'd0, 4'h2, 1'b0, 32'h7FFF1090, 32'hFF7F0888, 4'hF, 32'h7F7F0890, 1'b0);
    add_row("max_e2m1", MINMAX, 3'd1, 4'h5, 1'b0, 32'h0F0803F1, 32'h07000B02, 4'h0, 32'hF7F0F3F2, 1'b0);
    // Compares
    add_row("le_e5m2", CMP, 3'd0, 4'h1, 1'b0, 32'h3C00803C, 32'h3C800040, 4'h1, 32'h01010101, 1'b0);
    add_row("lt_e5m2", CMP, 3'd1, 4'h1, 1'b0, 32'h3C00803C, 32'h3C800040, 4'h2, 32'h00000001, 1'b0);
    add_row("eq_e5m2", CMP, 3'd2, 4'h1, 1'b0, 32'h3C00803C, 32'h3C800040, 4'h3, 32'h01010100, 1'b0);
    add_row("lt_qnan", CMP, 3'd1, 4'h1, 1'b0, 32'h7E3C3C3C, 32'h3C3C4038, 4'h4, 32'h00000100, 1'b1);
    add_row("eq_qnan", CMP, 3'd2, 4'h1, 1'b0, 32'h7E3C3C3C, 32'h3C3C4038, 4'h5, 32'h00010000, 1'b0);
    add_row("eq_snan", CMP, 3'd2, 4'h1, 1'b0, 32'h7D3C3C3C, 32'h3C3C4038, 4'h6, 32'h00010000, 1'b1);
    add_row("le_e2m1", CMP, 3'd0, 4'h5, 1'b0, 32'h08000901, 32'h00080109, 4'h7, 32'h01010100, 1'b0);
    // Classify
    add_row("class_e5m2_a", CLASS, 3'd0, 4'h1, 1'b0, 32'h813CBCFC, 32'h0, 4'h8, 32'h02060100, 1'b0);
    add_row("class_e5m2_b", CLASS, 3'd0, 4'h1, 1'b0, 32'h7D7C0180, 32'h0, 4'h9, 32'h08070503, 1'b0);
    add_row("class_unknown", CLASS, 3'd0, 4'hF, 1'b0, 32'h7E00FE7F, 32'h0, 4'hA, 32'h09040909, 1'b0);
    add_row("class_e4m3", CLASS, 3'd0, 4'h2, 1'b0, 32'h787F0880, 32'h0, 4'hB, 32'h06090603, 1'b0);
    add_row("class_e3m2", CLASS, 3'd0, 4'h3, 1'b0, 32'h213C0020, 32'h0, 4'hC, 32'h02010403, 1'b0);
    add_row("class_e2m1", CLASS, 3'd0, 4'h5, 1'b0, 32'h0F080102, 32'h0, 4'hD, 32'h01030506, 1'b0);
    // Operand B lane 0 broadcast
    add_row("rep_sgnj", SGNJ, 3'd0, 4'h1, 1'b1, 32'h04030201, 32'h11223380, 4'hE, 32'h84838281, 1'b0);
    add_row("rep_eq_e4m3", CMP, 3'd2, 4'h2, 1'b1, 32'h38403840, 32'hAABBCC38, 4'hF, 32'h01000100, 1'b0);
endtask

/* testbench/tb_sub8_fpu.sv */
// Sub-8 FPU testbench
module tb_sub8_fpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NL      = 4;
    localparam int TIMEOUT = 100;   // Cycles per wait
    localparam int LATENCY = 2;     // Request cycle to valid_o, two register stages

    typedef sub8_fpu_pkg::lane_t [NL-1:0] vec_t;

    localparam sub8_fpu_pkg::op_code_t SGNJ   = sub8_fpu_pkg::OP_SGNJ;
    localparam sub8_fpu_pkg::op_code_t MINMAX = sub8_fpu_pkg::OP_MINMAX;
    localparam sub8_fpu_pkg::op_code_t CMP    = sub8_fpu_pkg::OP_CMP;
    localparam sub8_fpu_pkg::op_code_t CLASS  = sub8_fpu_pkg::OP_CLASS;
    localparam sub8_fpu_pkg::op_code_t F2X    = sub8_fpu_pkg::OP_MV_F2X;
    localparam sub8_fpu_pkg::op_code_t X2F    = sub8_fpu_pkg::OP_MV_X2F;

    logic clk_i, rst_ni, flush_i, valid_i, replicate_i, result_ready_i;
    logic ready_o, valid_o, invalid_o;
    sub8_fpu_pkg::op_code_t  op_i;
    sub8_fpu_pkg::sub_op_t   sub_op_i;
    sub8_fpu_pkg::fmt_code_t fmt_i;
    sub8_fpu_pkg::tag_t      tag_i, tag_o;
    vec_t                    operand_a_i, operand_b_i, result_o;

    // Vector table, one entry per row
    string                   row_name[$];
    sub8_fpu_pkg::op_code_t  row_op[$];
    sub8_fpu_pkg::sub_op_t   row_sub[$];
    sub8_fpu_pkg::fmt_code_t row_fmt[$];
    logic                    row_rep[$];
    vec_t                    row_a[$], row_b[$], row_res[$];
    sub8_fpu_pkg::tag_t      row_tag[$];
    logic                    row_inv[$];

    int   exp_q[$];             // Accepted rows in order
    int   acc_cyc[64];          // Acceptance cycle per row
    int   cyc = 0;
    int   seed;
    logic saw_stall;            // ready_o seen low while valid

    sub8_fpu_top #(.NUM_LANES(NL)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;   // Edge counter

    `include "tb_vectors.svh"

    task automatic add_row(input string name, input sub8_fpu_pkg::op_code_t op,
                           input sub8_fpu_pkg::sub_op_t sub, input sub8_fpu_pkg::fmt_code_t fmt,
                           input logic rep, input vec_t a, input vec_t b,
                           input sub8_fpu_pkg::tag_t tag, input vec_t res, input logic inv);
        row_name.push_back(name);
        row_op.push_back(op);
        row_sub.push_back(sub);
        row_fmt.push_back(fmt);
        row_rep.push_back(rep);
        row_a.push_back(a);
        row_b.push_back(b);
        row_tag.push_back(tag);
        row_res.push_back(res);
        row_inv.push_back(inv);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_result(input string name, input vec_t exp, input vec_t act);
        if (act !== exp) fail_run($sformatf("Error %s result: expected %h, actual %h",
                                            name, exp, act));
    endtask

    task automatic check_invalid(input string name, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("Error %s invalid: expected %b, actual %b",
                                            name, exp, act));
    endtask

    task automatic check_tag(input string name, input sub8_fpu_pkg::tag_t exp,
                             input sub8_fpu_pkg::tag_t act);
        if (act !== exp) fail_run($sformatf("Error %s tag: expected %h, actual %h",
                                            name, exp, act));
    endtask

    // Present one row from a falling edge until it is accepted
    task automatic send_row(input int i);
        int waited;
        waited      = 0;
        op_i        = row_op[i];
        sub_op_i    = row_sub[i];
        fmt_i       = row_fmt[i];
        replicate_i = row_rep[i];
        operand_a_i = row_a[i];
        operand_b_i = row_b[i];
        tag_i       = row_tag[i];
        valid_i     = 1'b1;
        #1;
        while (!ready_o) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > TIMEOUT) fail_run("Timeout waiting for ready_o");
            @(negedge clk_i);
            #1;
        end
        exp_q.push_back(i);
        acc_cyc[i] = cyc;                   // Cycle ending in the acceptance edge
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    // Drive result_ready_i and check results in acceptance order
    task automatic collect(input int count, input logic rand_ready, input logic check_lat);
        int got, idle, idx, rnd;
        got  = 0;
        idle = 0;
        while (got < count) begin
            if (rand_ready) begin
                rnd            = $random(seed);
                result_ready_i = rnd[0];
            end else begin
                result_ready_i = 1'b1;
            end
            #1;
            if (valid_o && result_ready_i) begin
                if (exp_q.size() == 0) fail_run("A result came out with no request pending");
                idx = exp_q.pop_front();
                check_result(row_name[idx], row_res[idx], result_o);
                check_invalid(row_name[idx], row_inv[idx], invalid_o);
                check_tag(row_name[idx], row_tag[idx], tag_o);
                if (check_lat && (cyc - acc_cyc[idx]) != LATENCY)
                    fail_run($sformatf("Error %s latency: expected %0d, actual %0d",
                                       row_name[idx], LATENCY, cyc - acc_cyc[idx]));
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) fail_run("Timeout waiting for valid_o");
            end
            @(negedge clk_i);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        build_table();
        seed           = 32'h76cd40b1;
        saw_stall      = 1'b0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        op_i           = '0;
        sub_op_i       = '0;
        fmt_i          = '0;
        replicate_i    = 1'b0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        tag_i          = '0;
        result_ready_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        if (!ready_o || valid_o) fail_run("Handshake outputs wrong after reset");
        @(negedge clk_i);

        // One request at a time, sink always ready
        for (int i = 0; i < row_name.size(); i++) begin
            fork
                send_row(i);
                collect(1, 1'b0, 1'b1);
            join
        end

        // Back to back under random back-pressure
        saw_stall = 1'b0;
        fork
            begin
                for (int j = 0; j < row_name.size(); j++) send_row(j);
            end
            collect(row_name.size(), 1'b1, 1'b0);
        join
        if (!saw_stall) fail_run("ready_o never went low under back-pressure");

        // Two in flight with the sink stalled, then flush
        result_ready_i = 1'b0;
        send_row(0);
        send_row(1);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        exp_q.delete();                     // Flushed rows never come out
        #1;
        if (valid_o) fail_run("valid_o still high after flush");
        @(negedge clk_i);
        fork
            send_row(2);
            collect(1, 1'b0, 1'b0);
        join
        repeat (4) begin
            #1;
            if (valid_o) fail_run("Extra result after flush");
            @(negedge clk_i);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* rtl/sub8_fpu_top.sv */
// Sub-8 FPU wrapper top
module sub8_fpu_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     flush_i,
    input  logic                                     valid_i,
    input  sub8_fpu_pkg::op_code_t                   op_i,
    input  sub8_fpu_pkg::sub_op_t                    sub_op_i,
    input  sub8_fpu_pkg::fmt_code_t                  fmt_i,
    input  logic                                     replicate_i,
    input  sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_a_i,
    input  sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_b_i,
    input  sub8_fpu_pkg::tag_t                       tag_i,
    input  logic                                     result_ready_i,
    output logic                                     ready_o,
    output logic                                     valid_o,
    output sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  result_o,
    output logic                                     invalid_o,
    output sub8_fpu_pkg::tag_t                       tag_o
);

    // Issue to lanes and collector
    logic                                 issue_valid, issue_ready, stage_load;
    sub8_fpu_pkg::op_code_t               issue_op;
    sub8_fpu_pkg::sub_op_t                issue_sub_op;
    sub8_fpu_pkg::fp_fmt_t                issue_fmt;
    sub8_fpu_pkg::lane_t  [NUM_LANES-1:0] issue_a, issue_b;
    sub8_fpu_pkg::tag_t                   issue_tag;

    // Lanes to collector
    sub8_fpu_pkg::lane_t  [NUM_LANES-1:0] lane_result;
    logic                 [NUM_LANES-1:0] lane_invalid;

    sub8_issue #(.NUM_LANES(NUM_LANES)) u_issue (
        .clk_i, .rst_ni, .flush_i, .valid_i, .op_i, .sub_op_i, .fmt_i,
        .replicate_i, .operand_a_i, .operand_b_i, .tag_i,
        .issue_ready_i (issue_ready),
        .ready_o,
        .issue_valid_o (issue_valid),
        .op_o          (issue_op),
        .sub_op_o      (issue_sub_op),
        .fmt_o         (issue_fmt),
        .operand_a_o   (issue_a),
        .operand_b_o   (issue_b),
        .tag_o         (issue_tag)
    );

    // --------------------
    // Lane array
    // --------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        sub8_lane u_lane (
            .clk_i, .rst_ni,
            .stage_load_i (stage_load),
            .op_i         (issue_op),
            .sub_op_i     (issue_sub_op),
            .fmt_i        (issue_fmt),
            .a_i          (issue_a[i]),
            .b_i          (issue_b[i]),
            .result_o     (lane_result[i]),
            .invalid_o    (lane_invalid[i])
        );
    end

    sub8_collect #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk_i, .rst_ni, .flush_i,
        .issue_valid_i  (issue_valid),
        .tag_i          (issue_tag),
        .lane_result_i  (lane_result),
        .lane_invalid_i (lane_invalid),
        .result_ready_i,
        .issue_ready_o  (issue_ready),
        .stage_load_o   (stage_load),
        .valid_o, .result_o, .invalid_o, .tag_o
    );

endmodule

/* rtl/sub8_collect.sv */
// Result collector and ready chain
module sub8_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  flush_i,
    input  logic                                  issue_valid_i,
    input  sub8_fpu_pkg::tag_t                    tag_i,
    input  sub8_fpu_pkg::lane_t  [NUM_LANES-1:0]  lane_result_i,
    input  logic                 [NUM_LANES-1:0]  lane_invalid_i,
    input  logic                                  result_ready_i,
    output logic                                  issue_ready_o,
    output logic                                  stage_load_o,
    output logic                                  valid_o,
    output sub8_fpu_pkg::lane_t  [NUM_LANES-1:0]  result_o,
    output logic                                  invalid_o,
    output sub8_fpu_pkg::tag_t                    tag_o
);

    logic               stage_valid_q;  // Stage one occupied
    sub8_fpu_pkg::tag_t stage_tag_q;    // Tag travelling with stage one
    logic               out_load;       // Output register may take new data

    // --------------------
    // Ready chain
    // --------------------
    assign out_load      = ~valid_o | result_ready_i;       // Empty or being taken
    assign issue_ready_o = ~stage_valid_q | out_load;       // Empty or advancing
    assign stage_load_o  = issue_valid_i & issue_ready_o;   // Lanes capture

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
        if (!rst_ni) begin
            stage_valid_q <= 1'b0;
            valid_o       <= 1'b0;
        end else if (flush_i) begin
            stage_valid_q <= 1'b0;   // Drop everything in flight
            valid_o       <= 1'b0;
        end else begin
            if (issue_ready_o) stage_valid_q <= issue_valid_i;
            if (out_load)      valid_o       <= stage_valid_q;
        end
    end

    // Payload follows the valids
    always_ff @(posedge clk_i) begin : payload_regs
        if (stage_load_o) stage_tag_q <= tag_i;
        if (out_load && stage_valid_q) begin
            result_o  <= lane_result_i;
            invalid_o <= |lane_invalid_i;   // Any lane raises invalid
            tag_o     <= stage_tag_q;
        end
    end

endmodule

/* rtl/sub8_lane.sv */
// Non-computational lane
module sub8_lane (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   stage_load_i,
    input  sub8_fpu_pkg::op_code_t op_i,
    input  sub8_fpu_pkg::sub_op_t  sub_op_i,
    input  sub8_fpu_pkg::fp_fmt_t  fmt_i,
    input  sub8_fpu_pkg::lane_t    a_i,
    input  sub8_fpu_pkg::lane_t    b_i,
    output sub8_fpu_pkg::lane_t    result_o,
    output logic                   invalid_o
);

    // Class of one operand in the given format
    function automatic sub8_fpu_pkg::class_t fp_class(input sub8_fpu_pkg::lane_t x,
                                                      input sub8_fpu_pkg::fp_fmt_t f);
        logic       sgn;
        logic [4:0] ex;
        logic [2:0] man;
        logic       inf;
        logic       snan;
        logic       qnan;
        inf  = 1'b0;
        snan = 1'b0;
        qnan = 1'b0;
        case (f)
            sub8_fpu_pkg::FMT_E4M3: begin
                sgn = x[7]; ex = {1'b0, x[6:3]}; man = x[2:0];
                qnan = &x[6:0];                      // S.1111.111 only
            end
            sub8_fpu_pkg::FMT_E3M2: begin
                sgn = x[5]; ex = {2'b0, x[4:2]}; man = {1'b0, x[1:0]};
            end
            sub8_fpu_pkg::FMT_E2M3: begin
                sgn = x[5]; ex = {3'b0, x[4:3]}; man = x[2:0];
            end
            sub8_fpu_pkg::FMT_E2M1: begin
                sgn = x[3]; ex = {3'b0, x[2:1]}; man = {2'b0, x[0]};
            end
            default: begin                            // E5M2
                sgn = x[7]; ex = x[6:2]; man = {1'b0, x[1:0]};
                if (&x[6:2]) begin
                    inf  = (x[1:0] == 2'b00);
                    qnan = x[1];                      // Mantissa MSB marks quiet
                    snan = (x[1:0] == 2'b01);
                end
            end
        endcase
        if (qnan)                        fp_class = sub8_fpu_pkg::CLS_QNAN;
        else if (snan)                   fp_class = sub8_fpu_pkg::CLS_SNAN;
        else if (inf)                    fp_class = sgn ? sub8_fpu_pkg::CLS_NEG_INF
                                                        : sub8_fpu_pkg::CLS_POS_INF;
        else if (ex == '0 && man == '0)  fp_class = sgn ? sub8_fpu_pkg::CLS_NEG_ZERO
                                                        : sub8_fpu_pkg::CLS_POS_ZERO;
        else if (ex == '0)               fp_class = sgn ? sub8_fpu_pkg::CLS_NEG_SUB
                                                        : sub8_fpu_pkg::CLS_POS_SUB;
        else                             fp_class = sgn ? sub8_fpu_pkg::CLS_NEG_NORM
                                                        : sub8_fpu_pkg::CLS_POS_NORM;
    endfunction

    sub8_fpu_pkg::class_t cls_a, cls_b;
    sub8_fpu_pkg::lane_t  fmt_mask, sgn_mask;    // Format bits and sign bit
    sub8_fpu_pkg::lane_t  mag_a, mag_b;
    logic sign_a, sign_b, sign_new;
    logic any_nan, any_snan, a_nan, b_nan, both_zero;
    logic a_lt_b, a_eq_b;                        // Total order, -0 below +0
    sub8_fpu_pkg::lane_t  result_d;
    logic                 invalid_d;

    assign cls_a = fp_class(a_i, fmt_i);
    assign cls_b = fp_class(b_i, fmt_i);

    always_comb begin : lane_compute
        case (fmt_i)
            sub8_fpu_pkg::FMT_E3M2, sub8_fpu_pkg::FMT_E2M3: begin
                fmt_mask = 8'h3F; sgn_mask = 8'h20;
            end
            sub8_fpu_pkg::FMT_E2M1: begin
                fmt_mask = 8'h0F; sgn_mask = 8'h08;
            end
            default: begin
                fmt_mask = 8'hFF; sgn_mask = 8'h80;
            end
        endcase
        sign_a    = |(a_i & sgn_mask);
        sign_b    = |(b_i & sgn_mask);
        mag_a     = a_i & fmt_mask & ~sgn_mask;  // Upper box bits dropped
        mag_b     = b_i & fmt_mask & ~sgn_mask;
        a_nan     = cls_a >= sub8_fpu_pkg::CLS_SNAN;
        b_nan     = cls_b >= sub8_fpu_pkg::CLS_SNAN;
        any_nan   = a_nan | b_nan;
        any_snan  = (cls_a == sub8_fpu_pkg::CLS_SNAN) | (cls_b == sub8_fpu_pkg::CLS_SNAN);
        both_zero = (mag_a == '0) && (mag_b == '0);
        a_eq_b    = (sign_a == sign_b) && (mag_a == mag_b);
        if (sign_a != sign_b) a_lt_b = sign_a;
        else                  a_lt_b = sign_a ? (mag_a > mag_b) : (mag_a < mag_b);

        case (sub_op_i)
            3'b001:  sign_new = ~sign_b;         // sgnjn
            3'b010:  sign_new = sign_a ^ sign_b; // sgnjx
            default: sign_new = sign_b;          // sgnj
        endcase

        invalid_d = 1'b0;
        case (op_i)
            sub8_fpu_pkg::OP_SGNJ: result_d = mag_a | (sign_new ? sgn_mask : 8'h00) | ~fmt_mask;
            sub8_fpu_pkg::OP_MINMAX: begin
                invalid_d = any_snan;
                if (a_nan && b_nan)
                    result_d = (fmt_i == sub8_fpu_pkg::FMT_E4M3) ? 8'h7F : 8'h7E;
                else if (a_nan) result_d = b_i;
                else if (b_nan) result_d = a_i;
                else result_d = (a_lt_b ^ sub_op_i[0]) ? a_i : b_i;  // Bit 0 selects max
                result_d = result_d | ~fmt_mask;
            end
            sub8_fpu_pkg::OP_CMP: begin
                case (sub_op_i)
                    3'b000:  result_d = {7'b0, ~any_nan & (a_lt_b | a_eq_b | both_zero)};
                    3'b001:  result_d = {7'b0, ~any_nan & a_lt_b & ~both_zero};
                    default: result_d = {7'b0, ~any_nan & (a_eq_b | both_zero)};
                endcase
                // Ordered compares signal on any NaN, eq only on sNaN
                invalid_d = (sub_op_i[1] == 1'b0) ? any_nan : any_snan;
            end
            sub8_fpu_pkg::OP_CLASS:  result_d = {4'b0, cls_a};
            sub8_fpu_pkg::OP_MV_X2F: result_d = a_i | ~fmt_mask;
            default:                 result_d = a_i;   // F2X raw
        endcase
    end

    // Stage one register
    always_ff @(posedge clk_i or negedge rst_ni) begin : stage_reg
        if (!rst_ni) begin
            result_o  <= '0;
            invalid_o <= 1'b0;
        end else if (stage_load_i) begin
            result_o  <= result_d;
            invalid_o <= invalid_d;
        end
    end

endmodule

/* rtl/sub8_issue.sv */
// Issue stage with hold register
module sub8_issue #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     flush_i,
    input  logic                                     valid_i,
    input  sub8_fpu_pkg::op_code_t                   op_i,
    input  sub8_fpu_pkg::sub_op_t                    sub_op_i,
    input  sub8_fpu_pkg::fmt_code_t                  fmt_i,
    input  logic                                     replicate_i,
    input  sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_a_i,
    input  sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_b_i,
    input  sub8_fpu_pkg::tag_t                       tag_i,
    input  logic                                     issue_ready_i,
    output logic                                     ready_o,
    output logic                                     issue_valid_o,
    output sub8_fpu_pkg::op_code_t                   op_o,
    output sub8_fpu_pkg::sub_op_t                    sub_op_o,
    output sub8_fpu_pkg::fp_fmt_t                    fmt_o,
    output sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_a_o,
    output sub8_fpu_pkg::lane_t     [NUM_LANES-1:0]  operand_b_o,
    output sub8_fpu_pkg::tag_t                       tag_o
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e state_q, state_d;

    // Decoded request straight from the inputs
    sub8_fpu_pkg::fp_fmt_t                   fmt_d;
    sub8_fpu_pkg::lane_t   [NUM_LANES-1:0]   operand_b_d;

    // Held copy of a stalled request
    sub8_fpu_pkg::op_code_t                  op_q;
    sub8_fpu_pkg::sub_op_t                   sub_op_q;
    sub8_fpu_pkg::fp_fmt_t                   fmt_q;
    sub8_fpu_pkg::lane_t   [NUM_LANES-1:0]   operand_a_q;
    sub8_fpu_pkg::lane_t   [NUM_LANES-1:0]   operand_b_q;
    sub8_fpu_pkg::tag_t                      tag_q;

    logic hold_inputs;  // Capture request into hold register
    logic use_hold;     // Present held copy downstream

    // --------------------
    // Decode
    // --------------------
    always_comb begin : decode
        case (fmt_i)
            sub8_fpu_pkg::FMT_CODE_E4M3: fmt_d = sub8_fpu_pkg::FMT_E4M3;
            sub8_fpu_pkg::FMT_CODE_E3M2: fmt_d = sub8_fpu_pkg::FMT_E3M2;
            sub8_fpu_pkg::FMT_CODE_E2M3: fmt_d = sub8_fpu_pkg::FMT_E2M3;
            sub8_fpu_pkg::FMT_CODE_E2M1: fmt_d = sub8_fpu_pkg::FMT_E2M1;
            default:                     fmt_d = sub8_fpu_pkg::FMT_E5M2;  // Incl. unknown codes
        endcase
        // Broadcast lane 0 of B when replicating
        for (int i = 0; i < NUM_LANES; i++) begin
            operand_b_d[i] = replicate_i ? operand_b_i[0] : operand_b_i[i];
        end
    end

    // --------------------
    // Protocol inversion FSM
    // --------------------
    always_comb begin : issue_fsm
        ready_o       = 1'b0;
        issue_valid_o = 1'b0;
        hold_inputs   = 1'b0;
        use_hold      = 1'b0;
        state_d       = state_q;

        case (state_q)
            READY: begin
                ready_o       = 1'b1;       // Upstream sees ready first
                issue_valid_o = valid_i;
                // Pipeline refused, park the request
                if (valid_i && !issue_ready_i) begin
                    ready_o     = 1'b0;
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                issue_valid_o = 1'b1;       // Held request pending
                use_hold      = 1'b1;
                if (issue_ready_i) begin
                    ready_o = 1'b1;         // Handshake completes with held copy
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush drops any held request
        if (flush_i) state_d = READY;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : hold_reg
        if (hold_inputs) begin
            op_q        <= op_i;
            sub_op_q    <= sub_op_i;
            fmt_q       <= fmt_d;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_d;  // Already replicated
            tag_q       <= tag_i;
        end
    end

    // Output mux, held copy while stalled
    assign op_o        = use_hold ? op_q        : op_i;
    assign sub_op_o    = use_hold ? sub_op_q    : sub_op_i;
    assign fmt_o       = use_hold ? fmt_q       : fmt_d;
    assign operand_a_o = use_hold ? operand_a_q : operand_a_i;
    assign operand_b_o = use_hold ? operand_b_q : operand_b_d;
    assign tag_o       = use_hold ? tag_q       : tag_i;

endmodule

/* rtl/sub8_fpu_pkg.sv */
// Sub-8 FPU shared definitions
package sub8_fpu_pkg;

    // --------------------
    // Widths and types
    // --------------------
    localparam int LANE_W = 8;               // One lane of the packed operand

    typedef logic [LANE_W-1:0] lane_t;       // Raw lane bit pattern
    typedef logic [3:0]        fmt_code_t;   // External format code, sub8 CSR encoding
    typedef logic [2:0]        fp_fmt_t;     // Decoded internal format
    typedef logic [2:0]        op_code_t;    // Operation
    typedef logic [2:0]        sub_op_t;     // Operation modifier
    typedef logic [3:0]        tag_t;        // Transaction tag
    typedef logic [3:0]        class_t;      // Classify result index

    // --------------------
    // External format codes
    // --------------------
    localparam fmt_code_t FMT_CODE_E5M2 = 4'b0001;
    localparam fmt_code_t FMT_CODE_E4M3 = 4'b0010;
    localparam fmt_code_t FMT_CODE_E3M2 = 4'b0011;
    localparam fmt_code_t FMT_CODE_E2M3 = 4'b0100;
    localparam fmt_code_t FMT_CODE_E2M1 = 4'b0101;

    // Internal formats
    localparam fp_fmt_t FMT_E5M2 = 3'd0;     // FP8, IEEE-like specials
    localparam fp_fmt_t FMT_E4M3 = 3'd1;     // FP8, single NaN, no inf
    localparam fp_fmt_t FMT_E3M2 = 3'd2;     // FP6, all finite
    localparam fp_fmt_t FMT_E2M3 = 3'd3;     // FP6, all finite
    localparam fp_fmt_t FMT_E2M1 = 3'd4;     // FP4, all finite

    // --------------------
    // Operations
    // --------------------
    localparam op_code_t OP_SGNJ   = 3'd0;
    localparam op_code_t OP_MINMAX = 3'd1;
    localparam op_code_t OP_CMP    = 3'd2;
    localparam op_code_t OP_CLASS  = 3'd3;
    localparam op_code_t OP_MV_F2X = 3'd4;   // Raw pass-through
    localparam op_code_t OP_MV_X2F = 3'd5;   // Boxed move

    // Class indices
    localparam class_t CLS_NEG_INF  = 4'd0;
    localparam class_t CLS_NEG_NORM = 4'd1;
    localparam class_t CLS_NEG_SUB  = 4'd2;
    localparam class_t CLS_NEG_ZERO = 4'd3;
    localparam class_t CLS_POS_ZERO = 4'd4;
    localparam class_t CLS_POS_SUB  = 4'd5;
    localparam class_t CLS_POS_NORM = 4'd6;
    localparam class_t CLS_POS_INF  = 4'd7;
    localparam class_t CLS_SNAN     = 4'd8;
    localparam class_t CLS_QNAN     = 4'd9;

endpackage
